/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_dma_subsystem
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard *.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass line appears in the simulator output.
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^\*\*\* PASSED \*\*\*$$'

clean:
	rm -rf $(OBJ_DIR)

/* dma_channel.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One channel engine. Requests are queued, run one at a time for len+1
// beat cycles, and each one ends in a single-cycle completion pulse.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module dma_channel import dma_pkg::*; (
  input  logic      aclk,
  input  logic      aresetn,
  dma_req_if.slave  s_req,
  dma_cpl_if.master m_cpl
);

  dma_req_t             q_mem [N_OUTSTANDING];         // Request queue storage.
  logic [QPTR_BITS-1:0] wr_ptr;                        // Next free slot.
  logic [QPTR_BITS-1:0] rd_ptr;                        // Oldest queued request.
  logic [OCC_BITS-1:0]  occ;                           // Queued plus active requests.

  dma_req_t             act_req;                       // Request being worked on.
  logic                 act_vld;                       // An active request exists.
  logic [LEN_BITS-1:0]  beat_cnt;                      // Beats done on act_req.

  logic                 push;                          // Request accepted this cycle.
  logic                 pop;                           // Head moves to the active slot.
  logic                 q_empty;                       // Nothing waiting behind act_req.
  logic                 last_beat;                     // Final beat of act_req.
  dma_cpl_t             cpl_word;                      // Completion built from act_req.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Queue
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign s_req.ready = (occ < OCC_BITS'(N_OUTSTANDING)); // Room counts the active one too.
  assign push        = s_req.valid && s_req.ready;
  assign q_empty     = (occ == OCC_BITS'(act_vld));    // Only the active one is held.
  assign pop         = !act_vld && !q_empty;           // Idle engine takes the head.
  assign last_beat   = act_vld && (beat_cnt == act_req.len);

  always_ff @(posedge aclk) begin
    if (push) begin
      q_mem[wr_ptr] <= s_req.req;                      // Accepted request fills the free slot.
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end else begin
      if (push) begin
        wr_ptr <= qptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= qptr_next(rd_ptr);
      end
      // A request leaves the count on its last beat, not on the pop.
      occ <= occ + OCC_BITS'(push) - OCC_BITS'(last_beat);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Beat engine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      act_vld  <= 1'b0;
      beat_cnt <= '0;
    end else if (pop) begin
      act_vld  <= 1'b1;                                // First beat is the next cycle.
      beat_cnt <= '0;
    end else if (last_beat) begin
      act_vld  <= 1'b0;                                // Idle for one cycle, then pop.
    end else if (act_vld) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (pop) begin
      act_req <= q_mem[rd_ptr];
    end
  end

  // Completion echoes the request's identity fields.
  always_comb begin
    cpl_word.pid    = act_req.pid;
    cpl_word.dest   = act_req.dest;
    cpl_word.host   = act_req.host;
    cpl_word.stream = act_req.stream;
  end

  assign m_cpl.valid = last_beat;                      // One pulse per request.
  assign m_cpl.cpl   = cpl_word;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // The collector queue depth relies on this bound.
  a_occ_bound: assert property (
    @(posedge aclk) disable iff (!aresetn) occ <= OCC_BITS'(N_OUTSTANDING))
    else $error("engine holds more than N_OUTSTANDING requests");

  // Back-to-back completions would mean a request was skipped or run twice.
  a_cpl_gap: assert property (
    @(posedge aclk) disable iff (!aresetn) m_cpl.valid |=> !m_cpl.valid)
    else $error("completion pulses on consecutive cycles");

endmodule

`default_nettype wire

/* dma_cpl_collector.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Completion collector. Each engine's completions land in their own queue,
// which a round-robin grant drains onto one registered completion output.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module dma_cpl_collector import dma_pkg::*; (
  input  logic      aclk,
  input  logic      aresetn,
  dma_cpl_if.slave  s_cpl [N_CHAN],
  dma_cpl_if.master m_cpl
);

  dma_cpl_t             q_mem  [N_CHAN][N_OUTSTANDING]; // Per-channel storage.
  logic [QPTR_BITS-1:0] wr_ptr [N_CHAN];
  logic [QPTR_BITS-1:0] rd_ptr [N_CHAN];
  logic [OCC_BITS-1:0]  cnt    [N_CHAN];               // Entries per queue.

  logic [N_CHAN-1:0]    in_vld;                        // Arriving completions.
  dma_cpl_t             in_cpl [N_CHAN];
  logic [N_CHAN-1:0]    q_empty;
  logic [N_CHAN-1:0]    q_full;

  logic [CHAN_BITS-1:0] rr_ptr;                        // Last channel served.
  logic [CHAN_BITS-1:0] grant_idx;                     // Channel popped this cycle.
  logic                 grant_vld;
  logic                 out_vld;
  dma_cpl_t             out_cpl;

  for (genvar i = 0; i < N_CHAN; i++) begin : g_in
    assign in_vld[i]  = s_cpl[i].valid;
    assign in_cpl[i]  = s_cpl[i].cpl;
    assign q_empty[i] = (cnt[i] == '0);
    assign q_full[i]  = (cnt[i] == OCC_BITS'(N_OUTSTANDING));
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Round-robin grant over non-empty queues
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    int cand;
    grant_vld = 1'b0;
    grant_idx = rr_ptr;
    for (int k = 1; k <= N_CHAN; k++) begin            // Search starts after rr_ptr.
      cand = (int'(rr_ptr) + k) % N_CHAN;
      if (!grant_vld && !q_empty[cand]) begin
        grant_vld = 1'b1;
        grant_idx = CHAN_BITS'(cand);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Queues
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge aclk) begin
    for (int i = 0; i < N_CHAN; i++) begin
      if (in_vld[i]) begin
        q_mem[i][wr_ptr[i]] <= in_cpl[i];              // Written on the arrival cycle.
      end
    end
  end

  always_ff @(posedge aclk) begin
    logic pop;
    if (!aresetn) begin
      for (int i = 0; i < N_CHAN; i++) begin
        wr_ptr[i] <= '0;
        rd_ptr[i] <= '0;
        cnt[i]    <= '0;
      end
    end else begin
      for (int i = 0; i < N_CHAN; i++) begin
        pop = grant_vld && (grant_idx == CHAN_BITS'(i));
        if (in_vld[i]) begin
          wr_ptr[i] <= qptr_next(wr_ptr[i]);
        end
        if (pop) begin
          rd_ptr[i] <= qptr_next(rd_ptr[i]);
        end
        cnt[i] <= cnt[i] + OCC_BITS'(in_vld[i]) - OCC_BITS'(pop);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      out_vld <= 1'b0;
      rr_ptr  <= '0;
    end else begin
      out_vld <= grant_vld;                            // One completion per cycle at most.
      if (grant_vld) begin
        rr_ptr <= grant_idx;                           // Served channel goes to the back.
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (grant_vld) begin
      out_cpl <= q_mem[grant_idx][rd_ptr[grant_idx]];
    end
  end

  assign m_cpl.valid = out_vld;
  assign m_cpl.cpl   = out_cpl;

  // An engine completion has no ready, so a full queue would lose it.
  a_no_overflow: assert property (
    @(posedge aclk) disable iff (!aresetn) (in_vld & q_full) == '0)
    else $error("completion written into a full queue");

endmodule

`default_nettype wire

/* dma_cpl_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Completion link. Each cycle with valid high carries one completion and
// the sink must take it, there is no ready.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

interface dma_cpl_if import dma_pkg::*; ();

  logic     valid;                                     // One completion this cycle.
  dma_cpl_t cpl;                                       // Completion word.

  modport master (
    output valid,
    output cpl
  );

  modport slave (
    input  valid,
    input  cpl
  );

endinterface

`default_nettype wire

/* dma_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared sizes, request and completion words of the DMA dispatcher.
// Every design file takes these by a wildcard import in its module header.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package dma_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int N_CHAN        = 4;                    // Number of channel engines.
  localparam int CHAN_BITS     = $clog2(N_CHAN);       // Width of a channel index.
  localparam int PID_BITS      = 6;                    // Process id width.
  localparam int VADDR_BITS    = 32;                   // Virtual address width.
  localparam int LEN_BITS      = 8;                    // Beat count, a request runs len+1.
  localparam int N_OUTSTANDING = 4;                    // Requests held per engine.

  // Queue pointer and occupancy widths, shared by engine and collector.
  localparam int QPTR_BITS = (N_OUTSTANDING > 1) ? $clog2(N_OUTSTANDING) : 1;
  localparam int OCC_BITS  = $clog2(N_OUTSTANDING + 1); // Holds 0..N_OUTSTANDING.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Words
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [PID_BITS-1:0]   pid;                        // Owning process.
    logic [CHAN_BITS-1:0]  dest;                       // Target engine.
    logic [VADDR_BITS-1:0] vaddr;                      // Start address, not translated.
    logic [LEN_BITS-1:0]   len;                        // Beats minus one.
    logic                  host;                       // Host side transfer.
    logic                  stream;                     // Stream side transfer.
  } dma_req_t;

  typedef struct packed {
    logic [PID_BITS-1:0]  pid;                         // Copied from the request.
    logic [CHAN_BITS-1:0] dest;                        // Engine that finished it.
    logic                 host;                        // Copied from the request.
    logic                 stream;                      // Copied from the request.
  } dma_cpl_t;

  // Circular queue pointer step, wraps after the last slot.
  function automatic logic [QPTR_BITS-1:0] qptr_next(input logic [QPTR_BITS-1:0] ptr);
    return (ptr == QPTR_BITS'(N_OUTSTANDING - 1)) ? '0 : ptr + 1'b1;
  endfunction

endpackage

`default_nettype wire

/* dma_req_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Valid/ready request link. The master holds valid and req stable until
// the edge where ready is also high, which is the transfer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

interface dma_req_if import dma_pkg::*; ();

  logic     valid;                                     // Request present.
  logic     ready;                                     // Slave can take it.
  dma_req_t req;                                       // Request word.

  // Request source side.
  modport master (
    output valid,
    output req,
    input  ready
  );

  // Request sink side.
  modport slave (
    input  valid,
    input  req,
    output ready
  );

endinterface

`default_nettype wire

/* dma_req_router.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational request steering. The incoming request goes to the engine
// named by its dest field and that engine's ready comes back upstream.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module dma_req_router import dma_pkg::*; (
  input  logic      aclk,
  input  logic      aresetn,
  dma_req_if.slave  s_req,
  dma_req_if.master m_req [N_CHAN]
);

  logic [N_CHAN-1:0] chan_ready;                       // Ready of every engine.
  logic [N_CHAN-1:0] chan_sel;                         // One-hot decode of dest.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fan-out
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < N_CHAN; i++) begin : g_out
    assign chan_sel[i]    = (s_req.req.dest == CHAN_BITS'(i)); // This engine is addressed.
    assign m_req[i].req   = s_req.req;                         // Word goes everywhere.
    assign m_req[i].valid = s_req.valid && chan_sel[i];        // Only one sees valid.
    assign chan_ready[i]  = m_req[i].ready;
  end

  // A full engine stalls only the requests that name it.
  assign s_req.ready = chan_ready[s_req.req.dest];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // A stalled request must wait unchanged, or the dest decode would move it
  // to another engine mid-handshake.
  property p_req_hold;
    @(posedge aclk) disable iff (!aresetn)
      (s_req.valid && !s_req.ready) |=> (s_req.valid && $stable(s_req.req));
  endproperty

  a_req_hold: assert property (p_req_hold)
    else $error("request changed or dropped while stalled");

endmodule

`default_nettype wire

/* dma_subsystem.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA request dispatcher top level. Plain request and completion ports are
// bundled into links for the router, the N_CHAN engines and the collector.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module dma_subsystem import dma_pkg::*; (
  input  logic                  aclk,
  input  logic                  aresetn,
  // Request port.
  input  logic                  req_valid,
  output logic                  req_ready,
  input  logic [PID_BITS-1:0]   req_pid,
  input  logic [CHAN_BITS-1:0]  req_dest,
  input  logic [VADDR_BITS-1:0] req_vaddr,
  input  logic [LEN_BITS-1:0]   req_len,
  input  logic                  req_host,
  input  logic                  req_stream,
  // Completion port.
  output logic                  cpl_valid,
  output logic [PID_BITS-1:0]   cpl_pid,
  output logic [CHAN_BITS-1:0]  cpl_dest,
  output logic                  cpl_host,
  output logic                  cpl_stream
);

  dma_req_if req_in ();                                // Bundled request port.
  dma_req_if chan_req [N_CHAN] ();                     // Router to engines.
  dma_cpl_if chan_cpl [N_CHAN] ();                     // Engines to collector.
  dma_cpl_if cpl_out ();                               // Bundled completion port.

  assign req_in.valid      = req_valid;
  assign req_in.req.pid    = req_pid;
  assign req_in.req.dest   = req_dest;
  assign req_in.req.vaddr  = req_vaddr;
  assign req_in.req.len    = req_len;
  assign req_in.req.host   = req_host;
  assign req_in.req.stream = req_stream;
  assign req_ready         = req_in.ready;

  assign cpl_valid  = cpl_out.valid;
  assign cpl_pid    = cpl_out.cpl.pid;
  assign cpl_dest   = cpl_out.cpl.dest;
  assign cpl_host   = cpl_out.cpl.host;
  assign cpl_stream = cpl_out.cpl.stream;

  dma_req_router u_router (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_req   (req_in),
    .m_req   (chan_req)
  );

  for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
    dma_channel u_channel (
      .aclk    (aclk),
      .aresetn (aresetn),
      .s_req   (chan_req[i]),
      .m_cpl   (chan_cpl[i])
    );
  end

  dma_cpl_collector u_collector (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_cpl   (chan_cpl),
    .m_cpl   (cpl_out)
  );

endmodule

`default_nettype wire

/* project.f */
dma_pkg.sv
dma_req_if.sv
dma_cpl_if.sv
dma_req_router.sv
dma_channel.sv
dma_cpl_collector.sv
dma_subsystem.sv
tb_dma_subsystem.sv

/* tb_dma_subsystem.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the DMA dispatcher. A directed back-pressure phase on
// channel 0 is followed by seeded random requests. Completions are checked
// against per-channel queues of expected completions.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_dma_subsystem import dma_pkg::*; ();

  localparam int CLK_PERIOD   = 100;                   // Clock period in ns.
  localparam int N_RANDOM     = 300;                   // Random requests.
  localparam int ACCEPT_LIMIT = 200;                   // Cycles a request may stall.
  localparam int DRAIN_LIMIT  = 2000;                  // Cycles to finish all work.
  localparam int QUIET_CYCLES = 20;                    // Watch for stray completions.

  logic                  aclk;
  logic                  aresetn;
  logic                  req_valid;
  logic                  req_ready;
  logic [PID_BITS-1:0]   req_pid;
  logic [CHAN_BITS-1:0]  req_dest;
  logic [VADDR_BITS-1:0] req_vaddr;
  logic [LEN_BITS-1:0]   req_len;
  logic                  req_host;
  logic                  req_stream;
  logic                  cpl_valid;
  logic [PID_BITS-1:0]   cpl_pid;
  logic [CHAN_BITS-1:0]  cpl_dest;
  logic                  cpl_host;
  logic                  cpl_stream;

  integer   seed;                                      // State of $random.
  dma_cpl_t exp_q [N_CHAN][$];                         // Expected completions per channel.
  int       acc_cnt;                                   // Requests accepted so far.
  int       cpl_cnt;                                   // Completions matched so far.

  dma_subsystem u_dut (.*);

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] %t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_cpl(input dma_cpl_t got, input dma_cpl_t exp);
    if (got.pid !== exp.pid) report_mismatch("cpl_pid", 32'(got.pid), 32'(exp.pid));
    if (got.dest !== exp.dest) report_mismatch("cpl_dest", 32'(got.dest), 32'(exp.dest));
    if (got.host !== exp.host) report_mismatch("cpl_host", 32'(got.host), 32'(exp.host));
    if (got.stream !== exp.stream) begin
      report_mismatch("cpl_stream", 32'(got.stream), 32'(exp.stream));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Raises a request on the next rising edge. Identity fields are random.
  task automatic present_req(input logic [CHAN_BITS-1:0] dest, input logic [LEN_BITS-1:0] len);
    @(posedge aclk);
    req_valid  <= 1'b1;
    req_pid    <= PID_BITS'($random(seed));
    req_dest   <= dest;
    req_vaddr  <= VADDR_BITS'($random(seed));
    req_len    <= len;
    req_host   <= 1'($random(seed));
    req_stream <= 1'($random(seed));
  endtask

  // Returns at the falling edge before the accepting rising edge.
  task automatic wait_accept(input int limit);
    int waited;
    waited = 0;
    @(negedge aclk);
    while (!req_ready) begin
      waited++;
      if (waited > limit) begin
        $display("request to channel %0d not accepted within %0d cycles", req_dest, limit);
        $display("*** FAILED ***");
        $fatal(1);
      end
      @(negedge aclk);
    end
  endtask

  function automatic int outstanding();
    int total;
    total = 0;
    for (int i = 0; i < N_CHAN; i++) total += exp_q[i].size();
    return total;
  endfunction

  task automatic wait_drain(input int limit);
    int waited;
    waited = 0;
    while (outstanding() != 0) begin                   // Monitor pops on the falling edge.
      if (waited == limit) begin
        $display("timeout waiting for completions");
        $display("*** FAILED ***");
        $fatal(1);
      end
      @(posedge aclk);
      waited++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Monitor and model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge aclk) begin : monitor
    dma_cpl_t got;
    dma_cpl_t exp;
    dma_cpl_t acc;
    if (aresetn) begin
      if (cpl_valid) begin
        got.pid    = cpl_pid;
        got.dest   = cpl_dest;
        got.host   = cpl_host;
        got.stream = cpl_stream;
        if (exp_q[cpl_dest].size() == 0) begin
          $display("unexpected completion at %t on channel %0d, nothing outstanding there",
                   $time, cpl_dest);
          $display("*** FAILED ***");
          $fatal(1);
        end else begin
          exp = exp_q[cpl_dest].pop_front();           // Oldest request of that channel.
          check_cpl(got, exp);
          cpl_cnt++;
        end
      end
      // Valid and ready here means a transfer on the coming rising edge.
      if (req_valid && req_ready) begin
        acc.pid    = req_pid;
        acc.dest   = req_dest;
        acc.host   = req_host;
        acc.stream = req_stream;
        exp_q[req_dest].push_back(acc);
        acc_cnt++;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : main
    int n_sent;
    $timeformat(-9, 0, " ns", 0);
    seed       = 32'h3e74c83a;
    acc_cnt    = 0;
    cpl_cnt    = 0;
    n_sent     = N_OUTSTANDING + 2 + N_RANDOM;
    aresetn    = 1'b0;
    req_valid  = 1'b0;
    req_pid    = '0;
    req_dest   = '0;
    req_vaddr  = '0;
    req_len    = '0;
    req_host   = 1'b0;
    req_stream = 1'b0;

    repeat (2) @(posedge aclk);
    aresetn <= 1'b1;
    @(negedge aclk);
    check_bit("req_ready", req_ready, 1'b1);           // All engines empty.
    check_bit("cpl_valid", cpl_valid, 1'b0);

    // Fill channel 0 with long requests, each one taken at once.
    for (int i = 0; i < N_OUTSTANDING; i++) begin
      present_req(CHAN_BITS'(0), LEN_BITS'(15));
      @(negedge aclk);
      check_bit("req_ready", req_ready, 1'b1);
    end
    present_req(CHAN_BITS'(0), LEN_BITS'(15));         // One more than the engine holds.
    @(negedge aclk);
    check_bit("req_ready", req_ready, 1'b0);
    wait_accept(ACCEPT_LIMIT);
    present_req(CHAN_BITS'(1), LEN_BITS'(15));         // Channel 0 is full again here.
    @(negedge aclk);
    check_bit("req_ready", req_ready, 1'b1);

    for (int n = 0; n < N_RANDOM; n++) begin
      if (($random(seed) & 3) == 0) begin
        @(posedge aclk);
        req_valid <= 1'b0;                             // Idle cycle between requests.
      end
      present_req(CHAN_BITS'($random(seed)), LEN_BITS'($random(seed) & 15));
      wait_accept(ACCEPT_LIMIT);
    end
    @(posedge aclk);
    req_valid <= 1'b0;

    wait_drain(DRAIN_LIMIT);
    repeat (QUIET_CYCLES) @(posedge aclk);             // A stray completion trips the monitor.

    if (acc_cnt == n_sent && cpl_cnt == n_sent) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("accepted %0d and completed %0d of %0d requests", acc_cnt, cpl_cnt, n_sent);
      $display("*** FAILED ***");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire
